/* hdl/ll_defines.svh */
////////////////////////////////////////////////////////////////////////////
// Widths and sizes for the 64-bit logic link receive path
// Lane width and data width are tied to the two-lane split in the concat
// FIFO depth must equal 2**LL_PTR_WIDTH
////////////////////////////////////////////////////////////////////////////

`ifndef LL_DEFINES_SVH
`define LL_DEFINES_SVH

// One PHY lane word
`define LL_LANE_WIDTH 40

// User data, split evenly over the two receive lanes
`define LL_DATA_WIDTH 64

// Receive FIFO
`define LL_FIFO_DEPTH 16
`define LL_PTR_WIDTH  4

`endif

/* hdl/ll_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types of the logic link slave
// FIFO entry keeps the last flag in its top bit
////////////////////////////////////////////////////////////////////////////

`include "ll_defines.svh"

package ll_pkg;

  // PHY lane word
  typedef logic [`LL_LANE_WIDTH-1:0] phy_word_t;

  // User data and FIFO entry (last flag on top)
  typedef logic [`LL_DATA_WIDTH-1:0] ll_data_t;
  typedef logic [`LL_DATA_WIDTH:0]   ll_word_t;

  // Online delay and strobe period, in clk_wr cycles
  typedef logic [15:0] delay_t;

  // Debug status word and its saturating counters
  typedef logic [31:0] debug_t;
  typedef logic [15:0] cnt16_t;

  // Online sync FSM
  typedef enum logic [1:0] {
    SYNC_OFFLINE = 2'd0,
    SYNC_WAIT    = 2'd1,
    SYNC_ONLINE  = 2'd2
  } sync_state_t;

endpackage

/* hdl/ll_rx_if.sv */
////////////////////////////////////////////////////////////////////////////
// Link between PHY concat and receive blocks
// All signals are single-cycle strobes, there is no back-pressure
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface ll_rx_if;

  // Unpacked receive word and its qualifiers
  ll_pkg::ll_word_t rx_word;
  logic             rx_pushbit;
  logic             rx_parity_err;

  // One pulse per word popped by the user
  logic             tx_credit;

  modport concat_side (
    output rx_word,
    output rx_pushbit,
    output rx_parity_err,
    input  tx_credit
  );

  modport receive_side (
    input  rx_word,
    input  rx_pushbit,
    input  rx_parity_err,
    output tx_credit
  );

endinterface

/* hdl/ll_auto_sync.sv */
////////////////////////////////////////////////////////////////////////////
// Online delay for tx and rx, plus periodic strobe user bit
// A delay of 0 behaves as 1, a strobe period of 0 disables the strobe
// Dropping an online input takes its delayed output low one cycle later
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ll_auto_sync (
  input  logic           clk_wr,
  input  logic           rst,
  input  logic           tx_online,
  input  logic           rx_online,
  input  ll_pkg::delay_t delay_x_value,
  input  ll_pkg::delay_t delay_y_value,
  input  ll_pkg::delay_t delay_z_value,
  output logic           tx_online_delay,
  output logic           rx_online_delay,
  output logic           tx_stb_userbit
);

  // Channel 0 is tx, channel 1 is rx
  logic [1:0]     online_in;
  logic [1:0]     online_out;
  ll_pkg::delay_t delay_in [2];
  ll_pkg::delay_t stb_cnt;

  assign online_in   = {rx_online, tx_online};
  assign delay_in[0] = delay_x_value;
  assign delay_in[1] = delay_y_value;

  ////////////////////////////////////////////////////////////////////////////
  // Online delay FSMs

  for (genvar i = 0; i < 2; i++) begin : g_sync
    ll_pkg::sync_state_t state;
    ll_pkg::delay_t      wait_cnt;

    always_ff @(posedge clk_wr) begin
      if (rst) begin
        state    <= ll_pkg::SYNC_OFFLINE;
        wait_cnt <= '0;
      end else if (!online_in[i]) begin
        state <= ll_pkg::SYNC_OFFLINE;
      end else begin
        case (state)
          ll_pkg::SYNC_OFFLINE: begin
            if (delay_in[i] <= ll_pkg::delay_t'(1)) begin
              state <= ll_pkg::SYNC_ONLINE;
            end else begin
              state    <= ll_pkg::SYNC_WAIT;
              wait_cnt <= delay_in[i] - ll_pkg::delay_t'(1);
            end
          end
          ll_pkg::SYNC_WAIT: begin
            // Last count of the wait goes straight online
            if (wait_cnt <= ll_pkg::delay_t'(1)) begin
              state <= ll_pkg::SYNC_ONLINE;
            end else begin
              wait_cnt <= wait_cnt - ll_pkg::delay_t'(1);
            end
          end
          default: state <= ll_pkg::SYNC_ONLINE;
        endcase
      end
    end

    assign online_out[i] = (state == ll_pkg::SYNC_ONLINE);
  end

  assign tx_online_delay = online_out[0];
  assign rx_online_delay = online_out[1];

  ////////////////////////////////////////////////////////////////////////////
  // Strobe generator

  // First pulse lands delay_z cycles after tx_online_delay rises
  always_ff @(posedge clk_wr) begin
    if (rst || !tx_online_delay) begin
      stb_cnt        <= '0;
      tx_stb_userbit <= 1'b0;
    end else if ((delay_z_value != '0) &&
                 (stb_cnt >= delay_z_value - ll_pkg::delay_t'(1))) begin
      stb_cnt        <= '0;
      tx_stb_userbit <= 1'b1;
    end else begin
      stb_cnt        <= stb_cnt + ll_pkg::delay_t'(1);
      tx_stb_userbit <= 1'b0;
    end
  end

endmodule

/* hdl/phy_link_concat.sv */
////////////////////////////////////////////////////////////////////////////
// Two-lane PHY unpack and single-lane transmit packing
// Lane bits between parity and the top flag are ignored
// Parity errors are flagged only on words that carry the push bit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ll_defines.svh"

module phy_link_concat (
  input  logic              clk_wr,
  input  logic              rst,
  input  ll_pkg::phy_word_t rx_phy0,
  input  ll_pkg::phy_word_t rx_phy1,
  output ll_pkg::phy_word_t tx_phy0,
  input  logic              tx_stb_userbit,
  ll_rx_if.concat_side      link
);

  // Data bits per lane, parity sits just above them
  localparam int LANE_DATA = `LL_DATA_WIDTH / 2;
  localparam int FLAG_BIT  = `LL_LANE_WIDTH - 1;

  logic [LANE_DATA:0] rx_lo_q;
  logic [LANE_DATA:0] rx_hi_q;
  logic               last_q;
  logic               push_q;
  ll_pkg::phy_word_t  tx_next;

  ////////////////////////////////////////////////////////////////////////////
  // Receive lanes

  always_ff @(posedge clk_wr) begin
    rx_lo_q <= rx_phy0[LANE_DATA:0];
    rx_hi_q <= rx_phy1[LANE_DATA:0];
    last_q  <= rx_phy1[FLAG_BIT];
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      push_q <= 1'b0;
    end else begin
      push_q <= rx_phy0[FLAG_BIT];
    end
  end

  assign link.rx_word    = {last_q, rx_hi_q[LANE_DATA-1:0], rx_lo_q[LANE_DATA-1:0]};
  assign link.rx_pushbit = push_q;

  // Even parity, so data xor parity is zero on a good lane
  assign link.rx_parity_err = push_q & ((^rx_lo_q) | (^rx_hi_q));

  ////////////////////////////////////////////////////////////////////////////
  // Transmit lane

  always_comb begin
    tx_next    = '0;
    tx_next[0] = link.tx_credit;
    tx_next[1] = tx_stb_userbit;
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= tx_next;
    end
  end

endmodule

/* hdl/ll_receive.sv */
////////////////////////////////////////////////////////////////////////////
// Receive FIFO with credit return and user stream output
// Pushes into a full FIFO are dropped and counted, never stalled
// Words with bad parity are stored and delivered, only counted
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ll_defines.svh"

module ll_receive (
  input  logic             clk_wr,
  input  logic             rst,
  input  logic             rx_online,
  input  logic             tx_online,
  ll_rx_if.receive_side    link,
  output ll_pkg::ll_data_t user_tdata,
  output logic             user_tlast,
  output logic             user_tvalid,
  input  logic             user_tready,
  output ll_pkg::debug_t   rx_st_debug_status
);

  // Extra top bit tells full from empty
  typedef logic [`LL_PTR_WIDTH:0] ptr_t;

  logic             in_push_q;
  logic             in_perr_q;
  ll_pkg::ll_word_t in_word_q;

  ll_pkg::ll_word_t fifo_mem [`LL_FIFO_DEPTH];
  ptr_t             wr_ptr;
  ptr_t             rd_ptr;
  logic             fifo_empty;
  logic             fifo_full;
  logic             fifo_wr;
  logic             fifo_rd;
  ll_pkg::ll_word_t fifo_head;

  logic             credit_q;
  ll_pkg::cnt16_t   perr_cnt;
  ll_pkg::cnt16_t   ovf_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Input stage

  // Pushes only count while rx is online
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      in_push_q <= 1'b0;
      in_perr_q <= 1'b0;
    end else begin
      in_push_q <= link.rx_pushbit & rx_online;
      in_perr_q <= link.rx_parity_err & rx_online;
    end
  end

  always_ff @(posedge clk_wr) begin
    in_word_q <= link.rx_word;
  end

  ////////////////////////////////////////////////////////////////////////////
  // FIFO, first word falls through

  assign fifo_empty = (wr_ptr == rd_ptr);
  assign fifo_full  = (wr_ptr[`LL_PTR_WIDTH] != rd_ptr[`LL_PTR_WIDTH]) &&
                      (wr_ptr[`LL_PTR_WIDTH-1:0] == rd_ptr[`LL_PTR_WIDTH-1:0]);
  assign fifo_wr    = in_push_q & ~fifo_full;
  assign fifo_rd    = user_tvalid & user_tready;

  always_ff @(posedge clk_wr) begin
    if (fifo_wr) begin
      fifo_mem[wr_ptr[`LL_PTR_WIDTH-1:0]] <= in_word_q;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (fifo_wr) begin
        wr_ptr <= wr_ptr + ptr_t'(1);
      end
      if (fifo_rd) begin
        rd_ptr <= rd_ptr + ptr_t'(1);
      end
    end
  end

  assign fifo_head   = fifo_mem[rd_ptr[`LL_PTR_WIDTH-1:0]];
  assign user_tvalid = ~fifo_empty;
  assign user_tdata  = fifo_head[`LL_DATA_WIDTH-1:0];
  assign user_tlast  = fifo_head[`LL_DATA_WIDTH];

  ////////////////////////////////////////////////////////////////////////////
  // Credit return

  // One credit per pop, next cycle
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= fifo_rd & tx_online;
    end
  end

  assign link.tx_credit = credit_q;

  ////////////////////////////////////////////////////////////////////////////
  // Debug counters

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      perr_cnt <= '0;
      ovf_cnt  <= '0;
    end else begin
      if (in_push_q && in_perr_q && (perr_cnt != '1)) begin
        perr_cnt <= perr_cnt + ll_pkg::cnt16_t'(1);
      end
      // Dropped word, FIFO already full
      if (in_push_q && fifo_full && (ovf_cnt != '1)) begin
        ovf_cnt <= ovf_cnt + ll_pkg::cnt16_t'(1);
      end
    end
  end

  assign rx_st_debug_status = {ovf_cnt, perr_cnt};

endmodule

/* hdl/axi_st_d64_slave_top.sv */
////////////////////////////////////////////////////////////////////////////
// Receive-only 64-bit logic link slave, single clock domain
// Data on rx_phy0/rx_phy1, credits and strobe returned on tx_phy0
// Delay inputs are expected stable while the link is online
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axi_st_d64_slave_top (
  input  logic              clk_wr,
  input  logic              rst,

  // Link control
  input  logic              tx_online,
  input  logic              rx_online,

  // PHY lanes
  input  ll_pkg::phy_word_t rx_phy0,
  input  ll_pkg::phy_word_t rx_phy1,
  output ll_pkg::phy_word_t tx_phy0,

  // User stream
  output ll_pkg::ll_data_t  user_tdata,
  output logic              user_tlast,
  output logic              user_tvalid,
  input  logic              user_tready,

  // Debug and configuration
  output ll_pkg::debug_t    rx_st_debug_status,
  input  ll_pkg::delay_t    delay_x_value,
  input  ll_pkg::delay_t    delay_y_value,
  input  ll_pkg::delay_t    delay_z_value
);

  logic tx_online_delay;
  logic rx_online_delay;
  logic tx_stb_userbit;

  ll_rx_if link ();

  ////////////////////////////////////////////////////////////////////////////
  // Online sync and PHY side

  ll_auto_sync u_auto_sync (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_stb_userbit  (tx_stb_userbit)
  );

  phy_link_concat u_concat (
    .clk_wr         (clk_wr),
    .rst            (rst),
    .rx_phy0        (rx_phy0),
    .rx_phy1        (rx_phy1),
    .tx_phy0        (tx_phy0),
    .tx_stb_userbit (tx_stb_userbit),
    .link           (link)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Receive FIFO and user side

  ll_receive u_receive (
    .clk_wr             (clk_wr),
    .rst                (rst),
    .rx_online          (rx_online_delay),
    .tx_online          (tx_online_delay),
    .link               (link),
    .user_tdata         (user_tdata),
    .user_tlast         (user_tlast),
    .user_tvalid        (user_tvalid),
    .user_tready        (user_tready),
    .rx_st_debug_status (rx_st_debug_status)
  );

endmodule

/* tests/ll_slave_assert.sv */
////////////////////////////////////////////////////////////////////////////
// Protocol checks on the slave top level, attached with bind
// fail_count is read by the testbench at the end of the run
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ll_defines.svh"

module ll_slave_assert (
  input logic              clk_wr,
  input logic              rst,
  input ll_pkg::phy_word_t tx_phy0,
  input ll_pkg::ll_data_t  user_tdata,
  input logic              user_tlast,
  input logic              user_tvalid,
  input logic              user_tready
);

  int fail_count = 0;

  // Stalled word must hold until accepted
  hold_on_stall: assert property (@(posedge clk_wr) disable iff (rst)
    (user_tvalid && !user_tready) |=>
      (user_tvalid && $stable(user_tdata) && $stable(user_tlast)))
    else begin
      fail_count++;
      $error("user stream word changed or dropped while stalled");
    end

  // Only credit and strobe bits may be set on the transmit lane
  tx_upper_zero: assert property (@(posedge clk_wr) disable iff (rst)
    tx_phy0[`LL_LANE_WIDTH-1:2] == '0)
    else begin
      fail_count++;
      $error("tx_phy0 upper bits not zero");
    end

  no_valid_in_reset: assert property (@(posedge clk_wr) $past(rst) |-> !user_tvalid)
    else begin
      fail_count++;
      $error("user_tvalid high during reset");
    end

endmodule

bind axi_st_d64_slave_top ll_slave_assert u_assert (
  .clk_wr      (clk_wr),
  .rst         (rst),
  .tx_phy0     (tx_phy0),
  .user_tdata  (user_tdata),
  .user_tlast  (user_tlast),
  .user_tvalid (user_tvalid),
  .user_tready (user_tready)
);

/* tests/tb_axi_st_slave.sv */
////////////////////////////////////////////////////////////////////////////
// Directed tests for the logic link slave top level
// Inputs change on rising edges, outputs are sampled on falling edges
// Tests run in order and share link state, online stays up after test 2
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ll_defines.svh"

module tb_axi_st_slave;

  localparam int             WAIT_LIMIT = 200;
  localparam ll_pkg::delay_t DELAY_X    = 16'd5;
  localparam ll_pkg::delay_t DELAY_Y    = 16'd10;
  localparam ll_pkg::delay_t DELAY_Z    = 16'd8;

  logic              clk_wr = 1'b0;
  logic              rst;
  logic              tx_online;
  logic              rx_online;
  ll_pkg::phy_word_t rx_phy0;
  ll_pkg::phy_word_t rx_phy1;
  ll_pkg::phy_word_t tx_phy0;
  ll_pkg::ll_data_t  user_tdata;
  logic              user_tlast;
  logic              user_tvalid;
  logic              user_tready;
  ll_pkg::debug_t    rx_st_debug_status;
  ll_pkg::delay_t    delay_x_value;
  ll_pkg::delay_t    delay_y_value;
  ll_pkg::delay_t    delay_z_value;

  int                mismatch_count  = 0;
  int                failure_count   = 0;
  int                pop_count       = 0;
  int                credit_count    = 0;
  int                valid_cycles    = 0;
  int                delivered_total = 0;
  logic [31:0]       lfsr_state      = 32'h3350e155;
  logic [64:0]       model_q [$];

  axi_st_d64_slave_top uut (
    .clk_wr             (clk_wr),
    .rst                (rst),
    .tx_online          (tx_online),
    .rx_online          (rx_online),
    .rx_phy0            (rx_phy0),
    .rx_phy1            (rx_phy1),
    .tx_phy0            (tx_phy0),
    .user_tdata         (user_tdata),
    .user_tlast         (user_tlast),
    .user_tvalid        (user_tvalid),
    .user_tready        (user_tready),
    .rx_st_debug_status (rx_st_debug_status),
    .delay_x_value      (delay_x_value),
    .delay_y_value      (delay_y_value),
    .delay_z_value      (delay_z_value)
  );

  always #5 clk_wr = ~clk_wr;

  // Handshake, credit and valid monitors
  always @(negedge clk_wr) begin
    if (!rst) begin
      if (user_tvalid && user_tready) pop_count <= pop_count + 1;
      if (tx_phy0[0]) credit_count <= credit_count + 1;
      if (user_tvalid) valid_cycles <= valid_cycles + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_step()};
    end
    return v;
  endfunction

  // Lane word: data, even parity at bit 32, flag at bit 39
  function automatic ll_pkg::phy_word_t make_lane(input logic flag, input logic [31:0] d,
                                                  input logic bad_parity);
    ll_pkg::phy_word_t lane;
    lane     = '0;
    lane[31:0] = d;
    lane[32] = (^d) ^ bad_parity;
    lane[39] = flag;
    return lane;
  endfunction

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (expected === actual) else begin
      mismatch_count++;
      $display("MISMATCH %s: expected %h, actual %h", what, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    failure_count++;
    $display("ERROR: %s", what);
  endtask

  // Bit 0 of bad_parity corrupts lane 0, bit 1 corrupts lane 1
  task automatic push_word(input logic [63:0] data, input logic last,
                           input logic [1:0] bad_parity);
    @(posedge clk_wr);
    rx_phy0 <= make_lane(1'b1, data[31:0], bad_parity[0]);
    rx_phy1 <= make_lane(last, data[63:32], bad_parity[1]);
  endtask

  task automatic idle_lanes();
    @(posedge clk_wr);
    rx_phy0 <= '0;
    rx_phy1 <= '0;
  endtask

  // Accept count words and compare each with the model queue
  task automatic consume_words(input string name, input int count, input bit random_ready);
    int          got;
    int          idle;
    logic [64:0] exp;
    got  = 0;
    idle = 0;
    while (got < count && idle < WAIT_LIMIT) begin
      @(posedge clk_wr);
      user_tready <= random_ready ? lfsr_step() : 1'b1;
      @(negedge clk_wr);
      if (user_tvalid && user_tready) begin
        assert (model_q.size() != 0) else begin
          report_failure({name, ": word delivered that was never expected"});
        end
        if (model_q.size() != 0) begin
          exp = model_q.pop_front();
          check_value({name, " data"}, exp[63:0], user_tdata);
          check_value({name, " last"}, 64'(exp[64]), 64'(user_tlast));
        end
        got++;
        delivered_total++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    assert (got == count) else report_failure({name, ": timeout waiting for user words"});
    @(posedge clk_wr);
    user_tready <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests

  task automatic test_reset();
    for (int i = 0; i < 10; i++) begin
      @(posedge clk_wr);
      if (i == 9) rst <= 1'b0;
      @(negedge clk_wr);
      check_value("reset tvalid", 64'd0, 64'(user_tvalid));
      check_value("reset tx_phy0", 64'd0, 64'(tx_phy0));
      check_value("reset debug", 64'd0, 64'(rx_st_debug_status));
    end
    // First edge out of reset
    @(negedge clk_wr);
    check_value("after reset tvalid", 64'd0, 64'(user_tvalid));
    check_value("after reset tx_phy0", 64'd0, 64'(tx_phy0));
    check_value("after reset debug", 64'd0, 64'(rx_st_debug_status));
  endtask

  task automatic test_online_sync();
    int base_valid;
    int cycles;
    base_valid = valid_cycles;
    @(posedge clk_wr);
    rx_online <= 1'b1;
    // Well inside the rx delay, so these are dropped
    for (int i = 0; i < 3; i++) begin
      push_word(rand_bits(64), 1'b0, 2'b00);
    end
    idle_lanes();
    @(posedge clk_wr);
    tx_online <= 1'b1;
    cycles = 0;
    @(negedge clk_wr);
    while (!tx_phy0[1] && cycles < WAIT_LIMIT) begin
      @(negedge clk_wr);
      cycles++;
    end
    check_value("online_sync first strobe", 64'(DELAY_X + DELAY_Z + 16'd1), 64'(cycles));
    repeat (3) begin
      cycles = 0;
      do begin
        @(negedge clk_wr);
        cycles++;
      end while (!tx_phy0[1] && cycles < WAIT_LIMIT);
      check_value("online_sync strobe period", 64'(DELAY_Z), 64'(cycles));
    end
    check_value("online_sync early pushes", 64'd0, 64'(valid_cycles - base_valid));
    check_value("online_sync debug", 64'd0, 64'(rx_st_debug_status));
  endtask

  task automatic test_data_order();
    logic [63:0] words [40];
    logic        lasts [40];
    int          base;
    int          stall;
    for (int i = 0; i < 40; i++) begin
      words[i] = rand_bits(64);
      lasts[i] = lfsr_step();
    end
    base = delivered_total;
    fork
      begin
        for (int i = 0; i < 40; i++) begin
          // Keep the FIFO from filling, three words may be in flight
          stall = 0;
          while ((i - (delivered_total - base)) >= 12 && stall < WAIT_LIMIT) begin
            idle_lanes();
            stall++;
          end
          assert (stall < WAIT_LIMIT) else report_failure("data_order: producer stalled");
          push_word(words[i], lasts[i], 2'b00);
          model_q.push_back({lasts[i], words[i]});
          if ((i % 5) == 4) idle_lanes();
        end
        idle_lanes();
      end
      consume_words("data_order", 40, 1'b1);
    join
  endtask

  task automatic test_credit();
    int cycles;
    cycles = 0;
    @(negedge clk_wr);
    while ((credit_count != pop_count || user_tvalid) && cycles < WAIT_LIMIT) begin
      @(negedge clk_wr);
      cycles++;
    end
    assert (cycles < WAIT_LIMIT) else report_failure("credit: traffic did not drain");
    check_value("credit pulses", 64'(pop_count), 64'(credit_count));
    check_value("credit pops", 64'(delivered_total), 64'(pop_count));
    check_value("credit model empty", 64'd0, 64'(model_q.size()));
  endtask

  task automatic test_parity();
    logic [63:0] data;
    logic [1:0]  bad;
    for (int i = 0; i < 6; i++) begin
      data = rand_bits(64);
      // Lane 0 alone, lane 1 alone, then both lanes on one word
      bad  = {(i == 3) || (i == 4), (i == 1) || (i == 4)};
      push_word(data, 1'b0, bad);
      model_q.push_back({1'b0, data});
    end
    idle_lanes();
    consume_words("parity", 6, 1'b0);
    @(negedge clk_wr);
    check_value("parity error count", 64'd3, 64'(rx_st_debug_status[15:0]));
    check_value("parity overflow count", 64'd0, 64'(rx_st_debug_status[31:16]));
  endtask

  task automatic test_overflow();
    logic [63:0] data;
    for (int i = 0; i < 20; i++) begin
      data = rand_bits(64);
      push_word(data, i[0], 2'b00);
      if (i < `LL_FIFO_DEPTH) model_q.push_back({i[0], data});
    end
    idle_lanes();
    // Last push reaches the FIFO two edges after the lanes go idle
    repeat (2) @(posedge clk_wr);
    @(negedge clk_wr);
    check_value("overflow drop count", 64'd4, 64'(rx_st_debug_status[31:16]));
    consume_words("overflow", `LL_FIFO_DEPTH, 1'b0);
    @(negedge clk_wr);
    check_value("overflow drained", 64'd0, 64'(user_tvalid));
    check_value("overflow parity count", 64'd3, 64'(rx_st_debug_status[15:0]));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    int total;
    rst           = 1'b1;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    rx_phy0       = '0;
    rx_phy1       = '0;
    user_tready   = 1'b0;
    delay_x_value = DELAY_X;
    delay_y_value = DELAY_Y;
    delay_z_value = DELAY_Z;

    test_reset();
    test_online_sync();
    test_data_order();
    test_credit();
    test_parity();
    test_overflow();
    test_credit();

    total = mismatch_count + failure_count + uut.u_assert.fail_count;
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_count, failure_count, uut.u_assert.fail_count);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hdl
hdl/ll_pkg.sv
hdl/ll_rx_if.sv
hdl/ll_auto_sync.sv
hdl/phy_link_concat.sv
hdl/ll_receive.sv
hdl/axi_st_d64_slave_top.sv
tests/ll_slave_assert.sv
tests/tb_axi_st_slave.sv

/* Makefile */
# Verilator flow for the 64-bit logic link slave

TOP := tb_axi_st_slave

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
